//--- project.f
source/isa_pkg.sv
source/control_pkg.sv
source/instruction_decoder.sv
source/microcode_rom.sv
source/branch_condition.sv
source/fetch_execute_sequencer.sv
source/control_unit.sv
tests/control_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module control_unit_tb
output="$(./obj_dir/Vcontrol_unit_tb)"
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- tests/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb;

    localparam int RESET_CYCLES = 16;
    localparam int HALT_CYCLES  = 20;       // Cycles watched after the unit halts

    logic                             clk = 1'b0;
    logic                             reset;
    isa_pkg::opcode_t                 opcode;
    logic [isa_pkg::STATUS_WIDTH-1:0] flags;
    control_pkg::control_word_t       control_word;

    // Reference model state advanced on the falling edge
    control_pkg::seq_state_t model_state = control_pkg::S_RESET;
    logic [1:0]              model_bytes = '0;
    control_pkg::microstep_t model_step  = '0;
    int                      ir_loads    = 0;   // Opcode byte latches seen by the model

    isa_pkg::opcode_t prog_a[$];
    isa_pkg::opcode_t prog_b[$];
    isa_pkg::opcode_t active_prog[$];
    logic [31:0]      rng;
    int               budget = 0;
    int               errors = 0;
    int               checks = 0;

    control_unit i_dut (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Instruction set reference
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic legal_ref(input isa_pkg::opcode_t op);
        return op inside {[6'h00:6'h08], [6'h0b:6'h2a]};
    endfunction

    function automatic int operand_bytes(input isa_pkg::opcode_t op);
        if (op inside {[isa_pkg::JMP:isa_pkg::JNC], isa_pkg::LDA, isa_pkg::STA})
            return 2;
        if (op inside {isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C,
                       isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI})
            return 1;
        return 0;
    endfunction

    function automatic control_pkg::alu_op_t alu_code(input isa_pkg::opcode_t op);
        case (op)
            isa_pkg::ADD_B, isa_pkg::ADD_C:                 return control_pkg::ALU_ADD;
            isa_pkg::ADC_B, isa_pkg::ADC_C:                 return control_pkg::ALU_ADC;
            isa_pkg::SUB_B, isa_pkg::SUB_C,
            isa_pkg::CMP_B, isa_pkg::CMP_C:                 return control_pkg::ALU_SUB;
            isa_pkg::SBC_B, isa_pkg::SBC_C:                 return control_pkg::ALU_SBC;
            isa_pkg::INR_A:                                 return control_pkg::ALU_INR;
            isa_pkg::DCR_A:                                 return control_pkg::ALU_DCR;
            isa_pkg::ANA_B, isa_pkg::ANA_C, isa_pkg::ANI:   return control_pkg::ALU_AND;
            isa_pkg::ORA_B, isa_pkg::ORA_C, isa_pkg::ORI:   return control_pkg::ALU_OR;
            isa_pkg::XRA_B, isa_pkg::XRA_C, isa_pkg::XRI:   return control_pkg::ALU_XOR;
            default:                                        return control_pkg::ALU_UNDEFINED;
        endcase
    endfunction

    function automatic int step_count(input isa_pkg::opcode_t op);
        if (op inside {[isa_pkg::JMP:isa_pkg::JNC]})
            return 2;
        if (op inside {isa_pkg::LDA, isa_pkg::STA})
            return 6;
        if (alu_code(op) != control_pkg::ALU_UNDEFINED)
            return 2;
        return 1;   // NOP, HLT, moves, LDI and the illegal zero cycle
    endfunction

    function automatic int latency(input isa_pkg::opcode_t op);
        return 4 * (1 + operand_bytes(op)) + step_count(op);
    endfunction

    // False only for a conditional jump whose test fails
    function automatic logic jump_taken(input isa_pkg::opcode_t op, input logic [2:0] flg);
        case (op)
            isa_pkg::JZ:  return flg[isa_pkg::STATUS_ZERO];
            isa_pkg::JNZ: return !flg[isa_pkg::STATUS_ZERO];
            isa_pkg::JC:  return flg[isa_pkg::STATUS_CARRY];
            isa_pkg::JNC: return !flg[isa_pkg::STATUS_CARRY];
            isa_pkg::JN:  return flg[isa_pkg::STATUS_NEG];
            isa_pkg::JNN: return !flg[isa_pkg::STATUS_NEG];
            default:      return 1'b1;
        endcase
    endfunction

    // Microstep table per opcode
    function automatic control_pkg::control_word_t table_word(
        input isa_pkg::opcode_t        op,
        input control_pkg::microstep_t step
    );
        control_pkg::control_word_t w;
        logic                       imm;
        w = '0;
        imm = op inside {isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI,
                         isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C};
        if (op == isa_pkg::NOP) begin
            w.last_step = (step == 0);
        end else if (op == isa_pkg::HLT) begin
            w.halt = (step == 0);
        end else if (op inside {[isa_pkg::JMP:isa_pkg::JNC]}) begin
            if (step == 0) begin
                w.oe_temp_1          = 1'b1;
                w.load_pc_low_byte   = 1'b1;
                w.check_zero         = (op == isa_pkg::JZ);
                w.check_not_zero     = (op == isa_pkg::JNZ);
                w.check_carry        = (op == isa_pkg::JC);
                w.check_not_carry    = (op == isa_pkg::JNC);
                w.check_negative     = (op == isa_pkg::JN);
                w.check_not_negative = (op == isa_pkg::JNN);
            end else if (step == 1) begin
                w.oe_temp_2         = 1'b1;
                w.load_pc_high_byte = 1'b1;
                w.last_step         = 1'b1;
            end
        end else if (op inside {[isa_pkg::MOV_AB:isa_pkg::LDI_C]}) begin
            if (step == 0) begin
                // MOV_xy copies x into y
                w.oe_a         = op inside {isa_pkg::MOV_AB, isa_pkg::MOV_AC};
                w.oe_b         = op inside {isa_pkg::MOV_BA, isa_pkg::MOV_BC};
                w.oe_c         = op inside {isa_pkg::MOV_CA, isa_pkg::MOV_CB};
                w.load_a       = op inside {isa_pkg::MOV_BA, isa_pkg::MOV_CA, isa_pkg::LDI_A};
                w.load_b       = op inside {isa_pkg::MOV_AB, isa_pkg::MOV_CB, isa_pkg::LDI_B};
                w.load_c       = op inside {isa_pkg::MOV_AC, isa_pkg::MOV_BC, isa_pkg::LDI_C};
                w.oe_temp_1    = imm;
                w.load_status  = imm;
                w.load_sets_zn = imm;
                w.last_step    = 1'b1;
            end
        end else if (op inside {isa_pkg::LDA, isa_pkg::STA}) begin
            w.oe_temp_1          = (step == 0) || (step == 1);
            w.load_mar_addr_low  = (step == 1);
            w.oe_temp_2          = (step == 2) || (step == 3);
            w.load_mar_addr_high = (step == 3);
            if (step == 4 || step == 5) begin
                w.oe_ram = (op == isa_pkg::LDA);
                w.oe_a   = (op == isa_pkg::STA);
            end
            if (step == 5) begin
                w.load_a       = (op == isa_pkg::LDA);
                w.load_status  = (op == isa_pkg::LDA);
                w.load_sets_zn = (op == isa_pkg::LDA);
                w.load_ram     = (op == isa_pkg::STA);
                w.last_step    = 1'b1;
            end
        end else if (alu_code(op) != control_pkg::ALU_UNDEFINED) begin
            if (step == 0) begin
                w.alu_op         = alu_code(op);
                w.alu_src2_c     = op inside {isa_pkg::ADD_C, isa_pkg::ADC_C, isa_pkg::SUB_C,
                                              isa_pkg::SBC_C, isa_pkg::ANA_C, isa_pkg::ORA_C,
                                              isa_pkg::XRA_C, isa_pkg::CMP_C};
                w.alu_src2_temp1 = imm;
                w.oe_temp_1      = imm;
            end else if (step == 1) begin
                w.oe_alu      = !(op inside {isa_pkg::CMP_B, isa_pkg::CMP_C});
                w.load_a      = !(op inside {isa_pkg::CMP_B, isa_pkg::CMP_C});
                w.load_status = 1'b1;
                w.last_step   = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic control_pkg::control_word_t expected_word(
        input control_pkg::seq_state_t st,
        input logic [1:0]              bytes,
        input control_pkg::microstep_t step,
        input isa_pkg::opcode_t        op,
        input logic [2:0]              flg
    );
        control_pkg::control_word_t w;
        w = '0;
        case (st)
            control_pkg::S_INIT:       w.load_origin = 1'b1;
            control_pkg::S_LATCH_ADDR: w.load_mar_pc = 1'b1;
            control_pkg::S_READ_BYTE:  w.oe_ram = 1'b1;
            control_pkg::S_LATCH_BYTE: begin
                w.oe_ram      = 1'b1;
                w.pc_enable   = 1'b1;
                w.load_ir     = (bytes == 2'd0);
                w.load_temp_1 = (bytes == 2'd1);
                w.load_temp_2 = (bytes == 2'd2);
            end
            control_pkg::S_EXECUTE: begin
                if (legal_ref(op)) begin
                    w = table_word(op, step);
                    if (step == 0 && !jump_taken(op, flg)) begin
                        w.load_pc_low_byte  = 1'b0;
                        w.load_pc_high_byte = 1'b0;
                    end
                end
            end
            default: ;      // Reset, check and halt cycles are idle
        endcase
        return w;
    endfunction

    // ==============================
    // Compare process
    // ==============================
    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic advance_model();
        if (reset) begin
            model_state = control_pkg::S_RESET;
            model_bytes = '0;
            model_step  = '0;
        end else begin
            case (model_state)
                control_pkg::S_RESET:      model_state = control_pkg::S_INIT;
                control_pkg::S_INIT:       model_state = control_pkg::S_LATCH_ADDR;
                control_pkg::S_LATCH_ADDR: model_state = control_pkg::S_READ_BYTE;
                control_pkg::S_READ_BYTE:  model_state = control_pkg::S_LATCH_BYTE;
                control_pkg::S_LATCH_BYTE: begin
                    if (model_bytes == 2'd0)
                        ir_loads++;     // Next opcode goes out after this edge
                    model_bytes = model_bytes + 2'd1;
                    model_state = control_pkg::S_CHK_MORE_BYTES;
                end
                control_pkg::S_CHK_MORE_BYTES: begin
                    if (int'(model_bytes) > operand_bytes(opcode)) begin
                        model_bytes = '0;
                        model_state = control_pkg::S_EXECUTE;
                    end else begin
                        model_state = control_pkg::S_LATCH_ADDR;
                    end
                end
                control_pkg::S_EXECUTE: begin
                    if (!legal_ref(opcode) || opcode == isa_pkg::HLT) begin
                        model_state = control_pkg::S_HALT;
                    end else if ((model_step == 0 && !jump_taken(opcode, flags)) ||
                                 int'(model_step) == step_count(opcode) - 1) begin
                        model_step  = '0;
                        model_state = control_pkg::S_LATCH_ADDR;
                    end else begin
                        model_step = model_step + 3'd1;
                    end
                end
                default:                   model_state = control_pkg::S_HALT;
            endcase
        end
    endtask

    always @(negedge clk) begin
        control_pkg::control_word_t exp_word;
        exp_word = expected_word(model_state, model_bytes, model_step, opcode, flags);
        check_value("control_word", 64'(control_word), 64'(exp_word));
        advance_model();
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic run_program();
        int next_idx;
        int seen_loads;
        int halt_cycles;
        next_idx    = 0;
        halt_cycles = 0;
        reset       = 1'b1;
        opcode      = isa_pkg::NOP;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset      = 1'b0;
        seen_loads = ir_loads;
        while (halt_cycles < HALT_CYCLES) begin
            @(posedge clk);
            #1;
            if (ir_loads != seen_loads) begin
                seen_loads = ir_loads;
                if (next_idx < active_prog.size()) begin
                    opcode = active_prog[next_idx];
                    next_idx++;
                end
                rng   = lcg_next(rng);
                flags = rng[18:16];
            end
            if (model_state == control_pkg::S_HALT) begin
                halt_cycles++;
                rng   = lcg_next(rng);
                flags = rng[18:16];     // Flag changes in halt must not matter
            end
        end
    endtask

    initial begin
        reset  = 1'b1;
        opcode = isa_pkg::NOP;
        flags  = '0;
        rng    = 32'h4f32_979b;

        // One instruction per operand count then every legal opcode
        prog_a.push_back(isa_pkg::NOP);
        prog_a.push_back(isa_pkg::ANI);
        prog_a.push_back(isa_pkg::JMP);
        for (int v = 2; v < isa_pkg::NUM_OPCODES; v++) begin
            if (legal_ref(isa_pkg::opcode_t'(v[5:0])))
                prog_a.push_back(isa_pkg::opcode_t'(v[5:0]));
        end
        repeat (4) begin
            for (int v = isa_pkg::JZ; v <= isa_pkg::JNC; v++)
                prog_a.push_back(isa_pkg::opcode_t'(v[5:0]));
        end
        prog_a.push_back(isa_pkg::HLT);

        prog_b.push_back(isa_pkg::NOP);
        prog_b.push_back(isa_pkg::opcode_t'(6'h3f));    // Unused slot

        foreach (prog_a[i]) budget += latency(prog_a[i]);
        foreach (prog_b[i]) budget += latency(prog_b[i]);
        budget += 2 * (RESET_CYCLES + HALT_CYCLES + 4) + 200;

        active_prog = prog_a;
        run_program();
        active_prog = prog_b;
        run_program();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- source/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  isa_pkg::opcode_t                    opcode,     // From the instruction register
    input  logic [isa_pkg::STATUS_WIDTH-1:0]    flags,      // From the status register
    output control_pkg::control_word_t          control_word
);

    logic [isa_pkg::OPERAND_COUNT_WIDTH-1:0] operand_count;
    logic                                    legal;
    control_pkg::microstep_t                 microstep;
    control_pkg::control_word_t              rom_word;
    logic                                    jump_fail;

    instruction_decoder i_decoder (
        .opcode        (opcode),
        .operand_count (operand_count),
        .legal         (legal)
    );

    microcode_rom i_rom (
        .opcode    (opcode),
        .microstep (microstep),
        .rom_word  (rom_word)
    );

    branch_condition i_branch (
        .rom_word  (rom_word),
        .flags     (flags),
        .jump_fail (jump_fail)
    );

    fetch_execute_sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .rom_word      (rom_word),
        .jump_fail     (jump_fail),
        .operand_count (operand_count),
        .legal         (legal),
        .microstep     (microstep),
        .control_word  (control_word)
    );

endmodule

//--- source/fetch_execute_sequencer.sv
`timescale 1ns/10ps

module fetch_execute_sequencer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  control_pkg::control_word_t              rom_word,
    input  logic                                    jump_fail,
    input  logic [isa_pkg::OPERAND_COUNT_WIDTH-1:0] operand_count,
    input  logic                                    legal,
    output control_pkg::microstep_t                 microstep,
    output control_pkg::control_word_t              control_word
);

    control_pkg::seq_state_t                 state;
    control_pkg::seq_state_t                 next_state;
    logic [isa_pkg::OPERAND_COUNT_WIDTH-1:0] byte_count;     // Bytes latched this instruction
    logic [isa_pkg::OPERAND_COUNT_WIDTH-1:0] next_byte_count;
    control_pkg::microstep_t                 next_microstep;

    // ==============================
    // State registers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= control_pkg::S_RESET;
            byte_count <= '0;
            microstep  <= '0;
        end else begin
            state      <= next_state;
            byte_count <= next_byte_count;
            microstep  <= next_microstep;
        end
    end

    // ==============================
    // Next state and control word
    // ==============================
    always_comb begin
        next_state      = state;
        next_byte_count = byte_count;
        next_microstep  = microstep;
        control_word    = '0;       // All strobes low, ALU idle

        case (state)
            control_pkg::S_RESET: begin
                next_state = control_pkg::S_INIT;
            end
            control_pkg::S_INIT: begin
                control_word.load_origin = 1'b1;
                next_state = control_pkg::S_LATCH_ADDR;
            end
            // Four cycles per fetched byte
            control_pkg::S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state = control_pkg::S_READ_BYTE;
            end
            control_pkg::S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;     // RAM output settles
                next_state = control_pkg::S_LATCH_BYTE;
            end
            control_pkg::S_LATCH_BYTE: begin
                control_word.oe_ram    = 1'b1;
                control_word.pc_enable = 1'b1;
                case (byte_count)
                    2'd0:    control_word.load_ir     = 1'b1;
                    2'd1:    control_word.load_temp_1 = 1'b1;
                    default: control_word.load_temp_2 = 1'b1;
                endcase
                next_byte_count = byte_count + 1'b1;
                next_state      = control_pkg::S_CHK_MORE_BYTES;
            end
            control_pkg::S_CHK_MORE_BYTES: begin
                // Opcode byte plus operand_count operands
                if (byte_count > operand_count) begin
                    next_byte_count = '0;
                    next_state      = control_pkg::S_EXECUTE;
                end else begin
                    next_state = control_pkg::S_LATCH_ADDR;
                end
            end
            control_pkg::S_EXECUTE: begin
                if (!legal) begin
                    next_microstep = '0;
                    next_state     = control_pkg::S_HALT;
                end else begin
                    control_word = rom_word;
                    if (rom_word.halt) begin
                        next_microstep = '0;
                        next_state     = control_pkg::S_HALT;
                    end else if (jump_fail) begin
                        // Condition not met, keep PC on the next instruction
                        control_word.load_pc_low_byte  = 1'b0;
                        control_word.load_pc_high_byte = 1'b0;
                        next_microstep = '0;
                        next_state     = control_pkg::S_LATCH_ADDR;
                    end else if (rom_word.last_step) begin
                        next_microstep = '0;
                        next_state     = control_pkg::S_LATCH_ADDR;
                    end else begin
                        next_microstep = microstep + 1'b1;
                    end
                end
            end
            control_pkg::S_HALT: begin
                next_state = control_pkg::S_HALT;   // Left only by reset
            end
            default: begin
                next_state = control_pkg::S_HALT;
            end
        endcase
    end

endmodule

//--- source/branch_condition.sv
`timescale 1ns/10ps

module branch_condition (
    input  control_pkg::control_word_t          rom_word,
    input  logic [isa_pkg::STATUS_WIDTH-1:0]    flags,
    output logic                                jump_fail
);

    logic any_check;
    logic check_met;

    assign any_check = rom_word.check_zero     | rom_word.check_not_zero  |
                       rom_word.check_carry    | rom_word.check_not_carry |
                       rom_word.check_negative | rom_word.check_not_negative;

    // Any single met test lets the jump through
    assign check_met =
        (rom_word.check_zero         &&  flags[isa_pkg::STATUS_ZERO])  ||
        (rom_word.check_not_zero     && !flags[isa_pkg::STATUS_ZERO])  ||
        (rom_word.check_carry        &&  flags[isa_pkg::STATUS_CARRY]) ||
        (rom_word.check_not_carry    && !flags[isa_pkg::STATUS_CARRY]) ||
        (rom_word.check_negative     &&  flags[isa_pkg::STATUS_NEG])   ||
        (rom_word.check_not_negative && !flags[isa_pkg::STATUS_NEG]);

    assign jump_fail = any_check && !check_met;     // Plain JMP never fails

endmodule

//--- source/microcode_rom.sv
`timescale 1ns/10ps

module microcode_rom (
    input  isa_pkg::opcode_t            opcode,
    input  control_pkg::microstep_t     microstep,
    output control_pkg::control_word_t  rom_word
);

    control_pkg::control_word_t rom [isa_pkg::NUM_OPCODES][control_pkg::NUM_MICROSTEPS];

    // ==============================
    // Table builders
    // ==============================

    // Step 0 selects operands, step 1 writes A and flags
    task automatic set_alu(
        input isa_pkg::opcode_t     op,
        input control_pkg::alu_op_t alu_op,
        input logic                 src2_c,
        input logic                 src2_imm,
        input logic                 write_a
    );
        rom[op][0].alu_op         = alu_op;
        rom[op][0].alu_src2_c     = src2_c;
        rom[op][0].alu_src2_temp1 = src2_imm;
        rom[op][0].oe_temp_1      = src2_imm;   // Immediate rides the bus
        rom[op][1].oe_alu         = write_a;
        rom[op][1].load_a         = write_a;    // CMP keeps only the flags
        rom[op][1].load_status    = 1'b1;
        rom[op][1].last_step      = 1'b1;
    endtask

    // Checks are {z, nz, c, nc, n, nn}
    task automatic set_jump(input isa_pkg::opcode_t op, input logic [5:0] checks);
        rom[op][0].oe_temp_1        = 1'b1;
        rom[op][0].load_pc_low_byte = 1'b1;
        {rom[op][0].check_zero, rom[op][0].check_not_zero,
         rom[op][0].check_carry, rom[op][0].check_not_carry,
         rom[op][0].check_negative, rom[op][0].check_not_negative} = checks;
        rom[op][1].oe_temp_2         = 1'b1;
        rom[op][1].load_pc_high_byte = 1'b1;
        rom[op][1].last_step         = 1'b1;
    endtask

    // Single step transfer, src and dst one-hot {a, b, c}
    // No source register means the immediate in temp_1
    task automatic set_transfer(
        input isa_pkg::opcode_t op,
        input logic [2:0]       src,
        input logic [2:0]       dst
    );
        {rom[op][0].oe_a, rom[op][0].oe_b, rom[op][0].oe_c}       = src;
        {rom[op][0].load_a, rom[op][0].load_b, rom[op][0].load_c} = dst;
        rom[op][0].oe_temp_1    = (src == 3'b000);
        rom[op][0].load_status  = (src == 3'b000);
        rom[op][0].load_sets_zn = (src == 3'b000);
        rom[op][0].last_step    = 1'b1;
    endtask

    // Steps 0 to 3 move the operand address into MAR
    task automatic set_mem_address(input isa_pkg::opcode_t op);
        rom[op][0].oe_temp_1          = 1'b1;
        rom[op][1].oe_temp_1          = 1'b1;
        rom[op][1].load_mar_addr_low  = 1'b1;
        rom[op][2].oe_temp_2          = 1'b1;
        rom[op][3].oe_temp_2          = 1'b1;
        rom[op][3].load_mar_addr_high = 1'b1;
    endtask

    initial begin
        for (int i = 0; i < isa_pkg::NUM_OPCODES; i++) begin
            for (int s = 0; s < control_pkg::NUM_MICROSTEPS; s++) begin
                rom[i][s] = '0;
            end
        end

        rom[isa_pkg::NOP][0].last_step = 1'b1;
        rom[isa_pkg::HLT][0].halt      = 1'b1;

        set_jump(isa_pkg::JMP, 6'b000000);  // Unconditional
        set_jump(isa_pkg::JZ,  6'b100000);
        set_jump(isa_pkg::JNZ, 6'b010000);
        set_jump(isa_pkg::JC,  6'b001000);
        set_jump(isa_pkg::JNC, 6'b000100);
        set_jump(isa_pkg::JN,  6'b000010);
        set_jump(isa_pkg::JNN, 6'b000001);

        set_alu(isa_pkg::ADD_B, control_pkg::ALU_ADD, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::ADD_C, control_pkg::ALU_ADD, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::ADC_B, control_pkg::ALU_ADC, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::ADC_C, control_pkg::ALU_ADC, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::SUB_B, control_pkg::ALU_SUB, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::SUB_C, control_pkg::ALU_SUB, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::SBC_B, control_pkg::ALU_SBC, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::SBC_C, control_pkg::ALU_SBC, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::INR_A, control_pkg::ALU_INR, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::DCR_A, control_pkg::ALU_DCR, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::ANA_B, control_pkg::ALU_AND, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::ANA_C, control_pkg::ALU_AND, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::ANI,   control_pkg::ALU_AND, 1'b0, 1'b1, 1'b1);
        set_alu(isa_pkg::ORA_B, control_pkg::ALU_OR,  1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::ORA_C, control_pkg::ALU_OR,  1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::ORI,   control_pkg::ALU_OR,  1'b0, 1'b1, 1'b1);
        set_alu(isa_pkg::XRA_B, control_pkg::ALU_XOR, 1'b0, 1'b0, 1'b1);
        set_alu(isa_pkg::XRA_C, control_pkg::ALU_XOR, 1'b1, 1'b0, 1'b1);
        set_alu(isa_pkg::XRI,   control_pkg::ALU_XOR, 1'b0, 1'b1, 1'b1);
        set_alu(isa_pkg::CMP_B, control_pkg::ALU_SUB, 1'b0, 1'b0, 1'b0);
        set_alu(isa_pkg::CMP_C, control_pkg::ALU_SUB, 1'b1, 1'b0, 1'b0);

        set_transfer(isa_pkg::MOV_AB, 3'b100, 3'b010);
        set_transfer(isa_pkg::MOV_AC, 3'b100, 3'b001);
        set_transfer(isa_pkg::MOV_BA, 3'b010, 3'b100);
        set_transfer(isa_pkg::MOV_BC, 3'b010, 3'b001);
        set_transfer(isa_pkg::MOV_CA, 3'b001, 3'b100);
        set_transfer(isa_pkg::MOV_CB, 3'b001, 3'b010);
        set_transfer(isa_pkg::LDI_A,  3'b000, 3'b100);
        set_transfer(isa_pkg::LDI_B,  3'b000, 3'b010);
        set_transfer(isa_pkg::LDI_C,  3'b000, 3'b001);

        // LDA reads RAM into A
        set_mem_address(isa_pkg::LDA);
        rom[isa_pkg::LDA][4].oe_ram       = 1'b1;
        rom[isa_pkg::LDA][5].oe_ram       = 1'b1;
        rom[isa_pkg::LDA][5].load_a       = 1'b1;
        rom[isa_pkg::LDA][5].load_status  = 1'b1;
        rom[isa_pkg::LDA][5].load_sets_zn = 1'b1;
        rom[isa_pkg::LDA][5].last_step    = 1'b1;

        // STA writes A to RAM
        set_mem_address(isa_pkg::STA);
        rom[isa_pkg::STA][4].oe_a      = 1'b1;
        rom[isa_pkg::STA][5].oe_a      = 1'b1;
        rom[isa_pkg::STA][5].load_ram  = 1'b1;
        rom[isa_pkg::STA][5].last_step = 1'b1;
    end

    assign rom_word = rom[opcode][microstep];

endmodule

//--- source/instruction_decoder.sv
`timescale 1ns/10ps

module instruction_decoder (
    input  isa_pkg::opcode_t                        opcode,
    output logic [isa_pkg::OPERAND_COUNT_WIDTH-1:0] operand_count,
    output logic                                    legal
);

    always_comb begin
        operand_count = '0;
        legal         = 1'b1;
        case (opcode)
            isa_pkg::NOP, isa_pkg::HLT,
            isa_pkg::ADD_B, isa_pkg::ADD_C, isa_pkg::ADC_B, isa_pkg::ADC_C,
            isa_pkg::SUB_B, isa_pkg::SUB_C, isa_pkg::SBC_B, isa_pkg::SBC_C,
            isa_pkg::INR_A, isa_pkg::DCR_A,
            isa_pkg::ANA_B, isa_pkg::ANA_C, isa_pkg::ORA_B, isa_pkg::ORA_C,
            isa_pkg::XRA_B, isa_pkg::XRA_C, isa_pkg::CMP_B, isa_pkg::CMP_C,
            isa_pkg::MOV_AB, isa_pkg::MOV_AC, isa_pkg::MOV_BA,
            isa_pkg::MOV_BC, isa_pkg::MOV_CA, isa_pkg::MOV_CB: begin
                operand_count = 2'd0;
            end
            // Immediate byte follows
            isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C,
            isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI: begin
                operand_count = 2'd1;
            end
            // Address low then high
            isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JN,
            isa_pkg::JNN, isa_pkg::JC, isa_pkg::JNC,
            isa_pkg::LDA, isa_pkg::STA: begin
                operand_count = 2'd2;
            end
            default: begin
                legal = 1'b0;       // Halts once it reaches execute
            end
        endcase
    end

endmodule

//--- source/control_pkg.sv
package control_pkg;

    localparam int MICROSTEP_WIDTH = 3;
    localparam int NUM_MICROSTEPS  = 8;

    typedef logic [MICROSTEP_WIDTH-1:0] microstep_t;

    // ALU_UNDEFINED is zero so an all-zero word is idle
    typedef enum logic [3:0] {
        ALU_UNDEFINED = 4'd0,
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_INR, ALU_DCR,
        ALU_AND, ALU_OR, ALU_XOR
    } alu_op_t;

    typedef struct packed {
        // Fetch path
        logic    load_origin;
        logic    load_mar_pc;
        logic    oe_ram;
        logic    pc_enable;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    oe_temp_1;
        logic    oe_temp_2;
        // Program counter and memory address
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    load_ram;
        // Register file
        logic    oe_a;
        logic    oe_b;
        logic    oe_c;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        // ALU and status
        logic    oe_alu;
        logic    alu_src2_c;
        logic    alu_src2_temp1;
        logic    load_status;
        logic    load_sets_zn;      // Z and N from the bus, not the ALU
        // Jump tests, any one met lets the jump through
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    check_negative;
        logic    check_not_negative;
        // Sequencing
        logic    halt;
        logic    last_step;
        alu_op_t alu_op;
    } control_word_t;

    typedef enum logic [2:0] {
        S_RESET, S_INIT, S_LATCH_ADDR, S_READ_BYTE,
        S_LATCH_BYTE, S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } seq_state_t;

endpackage

//--- source/isa_pkg.sv
package isa_pkg;

    localparam int OPCODE_WIDTH        = 6;
    localparam int NUM_OPCODES         = 64;
    localparam int OPERAND_COUNT_WIDTH = 2;
    localparam int STATUS_WIDTH        = 3;

    // Flag vector bit positions
    localparam int STATUS_ZERO  = 0;
    localparam int STATUS_CARRY = 1;
    localparam int STATUS_NEG   = 2;

    // Gaps in the map are unused slots
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 6'h00,
        HLT    = 6'h01,
        // Jumps
        JMP    = 6'h02, JZ     = 6'h03, JNZ    = 6'h04, JN     = 6'h05,
        JNN    = 6'h06, JC     = 6'h07, JNC    = 6'h08,
        // Arithmetic on A
        ADD_B  = 6'h0b, ADD_C  = 6'h0c, ADC_B  = 6'h0d, ADC_C  = 6'h0e,
        SUB_B  = 6'h0f, SUB_C  = 6'h10, SBC_B  = 6'h11, SBC_C  = 6'h12,
        INR_A  = 6'h13, DCR_A  = 6'h14,
        // Logic and compare
        ANA_B  = 6'h15, ANA_C  = 6'h16, ANI    = 6'h17,
        ORA_B  = 6'h18, ORA_C  = 6'h19, ORI    = 6'h1a,
        XRA_B  = 6'h1b, XRA_C  = 6'h1c, XRI    = 6'h1d,
        CMP_B  = 6'h1e, CMP_C  = 6'h1f,
        // Register moves
        MOV_AB = 6'h20, MOV_AC = 6'h21, MOV_BA = 6'h22,
        MOV_BC = 6'h23, MOV_CA = 6'h24, MOV_CB = 6'h25,
        // Immediate loads and memory
        LDI_A  = 6'h26, LDI_B  = 6'h27, LDI_C  = 6'h28,
        LDA    = 6'h29,
        STA    = 6'h2a
    } opcode_t;

endpackage
